/* build.f */
+incdir+logic
logic/lnk_sym_pkg.sv
logic/lnk_ctl_pkg.sv
logic/lnk_apb_regs.sv
logic/lnk_lane_parser.sv
logic/lnk_descrambler.sv
logic/lnk_lock_vbid.sv
logic/dprx_lnk.sv
test/tb_dprx_lnk.sv

/* Bender.yml */
package:
  name: dprx_lnk

sources:
  - include_dirs:
      - logic
    files:
      - logic/lnk_sym_pkg.sv
      - logic/lnk_ctl_pkg.sv
      - logic/lnk_apb_regs.sv
      - logic/lnk_lane_parser.sv
      - logic/lnk_descrambler.sv
      - logic/lnk_lock_vbid.sv
      - logic/dprx_lnk.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_dprx_lnk.sv

/* test/tb_dprx_lnk.sv */
`timescale 1ns/1ps
`include "lnk_params.svh"

module tb_dprx_lnk
import lnk_sym_pkg::*;
import lnk_ctl_pkg::*;
();

    localparam int   BURST   = 48;                           // Cycles per data burst
    localparam int   N_APB   = 23;                           // Bus transfers of 3 cycles each
    localparam int   RUN_CYC = 4 * BURST + N_APB * 3 + 64;   // Bursts, bus and idle gaps
    localparam int   MARGIN  = 100;
    localparam sym_t K_FILL  = 8'hF7;                        // K23.7 is neither BS, BE nor SR

    logic                   LNK_CLK_IN = 1'b0;
    logic                   arst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`LNK_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic [`LNK_LANES-1:0]  lnk_k;
    sym_t [`LNK_LANES-1:0]  lnk_dat;
    logic [`LNK_LANES-1:0]  out_k;
    sym_t [`LNK_LANES-1:0]  out_dat;
    logic                   scrm_lock;
    sym_t                   vbid;
    logic                   vbid_vld;
    logic                   sync;

    int          errors = 0;
    logic [31:0] rng = 32'ha3b8;   // Stimulus LFSR state
    ctl_word_u   sh_ctl;           // Control word the DUT should hold
    logic        rd_chk;           // Read data check armed
    logic [31:0] rd_exp;
    logic        want_err;

    // Reference pipeline state
    logic [`LNK_LANES-1:0] m1_k;
    logic [`LNK_LANES-1:0] m1_sr;
    sym_t [`LNK_LANES-1:0] m1_dat;
    logic [15:0]           m_lfsr [`LNK_LANES];
    logic [`LNK_LANES-1:0] m_lock;
    logic [`LNK_LANES-1:0] lane_mask;
    logic [`LNK_LANES-1:0] exp_k;
    sym_t [`LNK_LANES-1:0] exp_dat;
    logic                  m1_bs;
    logic                  exp_bs;
    logic                  prev_bs;
    logic                  exp_lock;
    logic                  exp_vld;
    logic                  exp_sync;
    sym_t                  exp_vbid;

    dprx_lnk i_dut (.*);

    always #4 LNK_CLK_IN = ~LNK_CLK_IN; // 125 MHz link clock

    // One serial step of x^16+x^5+x^4+x^3+1
    function automatic logic [15:0] lfsr_step1(input logic [15:0] s);
        logic [15:0] n;
        n    = {s[14:0], 1'b0};
        n[0] = s[15];        // Feedback into the x^0 tap
        n[3] = n[3] ^ s[15];
        n[4] = n[4] ^ s[15];
        n[5] = n[5] ^ s[15];
        return n;
    endfunction

    // Key byte with bit 0 first out of the register
    function automatic sym_t lfsr_key8(input logic [15:0] s);
        sym_t key;
        for (int b = 0; b < 8; b++)
        begin
            key[b] = s[15];
            s      = lfsr_step1(s);
        end
        return key;
    endfunction

    function automatic logic [15:0] lfsr_adv8(input logic [15:0] s);
        for (int b = 0; b < 8; b++)
            s = lfsr_step1(s);
        return s;
    endfunction

    // Fibonacci stimulus source with taps 32 22 2 1
    function automatic logic [31:0] fib_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            rng = fib_next(rng);
            v   = {v[6:0], rng[0]}; // One step per bit
        end
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] want,
                                   input logic [31:0] got);
        errors++;
        $display("[ERROR] %0t %s: expected %h, got %h", $time, sig, want, got);
    endtask

    // Lanes in kmask carry K code kc and the others random data
    task automatic send_cycle(input logic [`LNK_LANES-1:0] kmask, input sym_t kc);
        sym_t [`LNK_LANES-1:0] d;
        logic [7:0]            r;
        for (int i = 0; i < `LNK_LANES; i++)
        begin
            take_bits(8, r);
            d[i] = kmask[i] ? kc : r;
        end
        @(posedge LNK_CLK_IN);
        lnk_k   <= kmask;
        lnk_dat <= d;
    endtask

    // Random data with K fill on about one lane in four and BS every 16 cycles
    task automatic send_burst(input int n);
        logic [7:0] r;
        for (int c = 0; c < n; c++)
        begin
            take_bits(8, r);
            if (c % 16 == 0)
                send_cycle('1, K_BS);
            else
                send_cycle(r[3:0] & r[7:4], K_FILL);
        end
    endtask

    task automatic send_idle(input int n);
        repeat (n)
        begin
            @(posedge LNK_CLK_IN);
            lnk_k   <= '1;
            lnk_dat <= {`LNK_LANES{K_FILL}};
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [`LNK_APB_AW-1:0] addr,
                            input logic [31:0] wdata, input logic chk,
                            input logic [31:0] want);
        int n;
        n = 0;
        @(posedge LNK_CLK_IN);
        psel    <= 1'b1; // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge LNK_CLK_IN);
        penable <= 1'b1; // Access phase
        rd_chk  <= chk;
        rd_exp  <= want;
        @(posedge LNK_CLK_IN);
        while (!pready && n < 4)
        begin
            n++;
            @(posedge LNK_CLK_IN);
        end
        if (!pready)
        begin
            errors++;
            $display("APB transfer to offset %h never completed", addr);
        end
        if (wr && addr == `LNK_REG_CTL)
            sh_ctl.raw <= wdata & 32'h0000_000F; // Reserved bits are dropped
        psel    <= 1'b0;
        penable <= 1'b0;
        rd_chk  <= 1'b0;
    endtask

    task automatic read_status();
        apb_xfer(1'b0, `LNK_REG_STA, '0, 1'b1, {16'h0, exp_vbid, 7'h0, exp_lock});
    endtask

    always_comb
    begin
        case (sh_ctl.f.lane_cnt)
            LANES_1: lane_mask = 4'b0001;
            LANES_2: lane_mask = 4'b0011;
            LANES_4: lane_mask = 4'b1111;
            default: lane_mask = 4'b0000; // No lanes so never locked
        endcase
    end

    assign want_err = psel && penable && !(paddr inside {`LNK_REG_CTL, `LNK_REG_STA});

    // Control side of the model with one register per pipeline stage
    always @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m1_k     <= '0;
            m1_sr    <= '0;
            m1_bs    <= 1'b0;
            exp_k    <= '0;
            m_lock   <= '0;
            exp_bs   <= 1'b0;
            prev_bs  <= 1'b0;
            exp_lock <= 1'b0;
            exp_vld  <= 1'b0;
            exp_sync <= 1'b0;
            exp_vbid <= '0;
            for (int i = 0; i < `LNK_LANES; i++)
                m_lfsr[i] <= LFSR_SEED;
        end
        else
        begin
            for (int i = 0; i < `LNK_LANES; i++)
            begin
                m1_sr[i]  <= lnk_k[i] && (lnk_dat[i] == K_SR);
                m_lfsr[i] <= m1_sr[i] ? LFSR_SEED : lfsr_adv8(m_lfsr[i]);
                if (!sh_ctl.f.lnk_en)
                    m_lock[i] <= 1'b0;
                else if (m1_sr[i])
                    m_lock[i] <= 1'b1;
            end
            m1_k     <= lnk_k;
            m1_bs    <= lnk_k[0] && (lnk_dat[0] == K_BS);
            exp_k    <= m1_k;
            exp_bs   <= m1_bs;
            exp_sync <= exp_bs;  // One register after BS leaves
            prev_bs  <= exp_bs;
            exp_lock <= (lane_mask != '0) && ((m_lock & lane_mask) == lane_mask);
            exp_vld  <= prev_bs && !exp_k[0];
            if (prev_bs && !exp_k[0])
                exp_vbid <= exp_dat[0];
        end
    end

    // Data side XORs with the key taken before the advance
    always @(posedge LNK_CLK_IN)
    begin
        m1_dat <= lnk_dat;
        for (int i = 0; i < `LNK_LANES; i++)
            exp_dat[i] <= (sh_ctl.f.scrm_en && !m1_k[i]) ?
                          (m1_dat[i] ^ lfsr_key8(m_lfsr[i])) : m1_dat[i];
    end

    a_out_k: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) out_k == exp_k)
        else report_mismatch("out_k", $sampled(exp_k), $sampled(out_k));
    a_out_dat: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) out_dat === exp_dat)
        else report_mismatch("out_dat", $sampled(exp_dat), $sampled(out_dat));
    a_lock: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) scrm_lock == exp_lock)
        else report_mismatch("scrm_lock", $sampled(exp_lock), $sampled(scrm_lock));
    a_vld: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) vbid_vld == exp_vld)
        else report_mismatch("vbid_vld", $sampled(exp_vld), $sampled(vbid_vld));
    a_vbid: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) vbid == exp_vbid)
        else report_mismatch("vbid", $sampled(exp_vbid), $sampled(vbid));
    a_sync: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) sync == exp_sync)
        else report_mismatch("sync", $sampled(exp_sync), $sampled(sync));
    a_ready: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n)
                              pready == (psel && penable))
        else report_mismatch("pready", $sampled(psel && penable), $sampled(pready));
    a_slverr: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n) pslverr == want_err)
        else report_mismatch("pslverr", $sampled(want_err), $sampled(pslverr));
    a_rdata: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n)
                              rd_chk |-> prdata == rd_exp)
        else report_mismatch("prdata", $sampled(rd_exp), $sampled(prdata));

    initial
    begin
        #((RUN_CYC + MARGIN) * 8);
        $display("Watchdog expired after %0d cycles, stimulus never finished", RUN_CYC + MARGIN);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lnk_k   = '1;
        lnk_dat = {`LNK_LANES{K_FILL}};
        rd_chk  = 1'b0;
        rd_exp  = '0;
        sh_ctl  = '0;
        repeat (2) @(posedge LNK_CLK_IN);
        arst_n <= 1'b1;

        // Register readback and bus errors
        apb_xfer(1'b1, `LNK_REG_CTL, 32'hFFF0_000F, 1'b0, '0);
        apb_xfer(1'b0, `LNK_REG_CTL, '0, 1'b1, 32'h0000_000F);
        apb_xfer(1'b0, 4'h8, '0, 1'b0, '0);             // Unmapped read
        apb_xfer(1'b1, 4'hC, 32'h1, 1'b0, '0);          // Unmapped write
        apb_xfer(1'b1, `LNK_REG_STA, 32'h0, 1'b0, '0);  // Ignored without error

        // Four lanes scrambled
        send_cycle('1, K_SR);
        send_burst(2 * BURST);
        send_idle(4);
        read_status();

        // Data passes through with the scrambler off
        apb_xfer(1'b1, `LNK_REG_CTL, 32'h7, 1'b0, '0);
        send_cycle('1, K_SR);
        send_burst(BURST);
        send_idle(4);
        read_status();

        // Lock per lane code with link off in between
        apb_xfer(1'b1, `LNK_REG_CTL, 32'h1, 1'b0, '0);  // Link on with no lanes
        send_cycle('1, K_SR);
        send_idle(4);
        read_status();                                  // Never locked
        apb_xfer(1'b1, `LNK_REG_CTL, 32'h0, 1'b0, '0);
        send_cycle('1, K_SR);                           // Ignored with link off
        apb_xfer(1'b1, `LNK_REG_CTL, 32'hB, 1'b0, '0);  // One lane
        send_cycle(4'b0001, K_SR);
        send_idle(4);
        read_status();
        apb_xfer(1'b1, `LNK_REG_CTL, 32'h0, 1'b0, '0);
        apb_xfer(1'b1, `LNK_REG_CTL, 32'hD, 1'b0, '0);  // Two lanes
        send_cycle(4'b0001, K_SR);
        send_idle(4);
        read_status();                                  // Lane 1 still unlocked
        send_cycle(4'b0010, K_SR);
        send_idle(4);
        read_status();
        apb_xfer(1'b1, `LNK_REG_CTL, 32'h0, 1'b0, '0);
        apb_xfer(1'b1, `LNK_REG_CTL, 32'hF, 1'b0, '0);  // Four lanes
        send_cycle(4'b0111, K_SR);
        send_idle(4);
        read_status();
        send_cycle(4'b1000, K_SR);
        send_burst(BURST);
        send_idle(4);
        read_status();
        apb_xfer(1'b1, `LNK_REG_CTL, 32'h0, 1'b0, '0);  // Lock falls
        send_idle(4);
        read_status();
        send_idle(8);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* logic/dprx_lnk.sv */
`timescale 1ns/1ps
`include "lnk_params.svh"

module dprx_lnk
import lnk_sym_pkg::*;
import lnk_ctl_pkg::*;
(
    input  logic                   LNK_CLK_IN,
    input  logic                   arst_n,

    // APB
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`LNK_APB_AW-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,

    // Link in, one symbol per lane per clock
    input  logic [`LNK_LANES-1:0]  lnk_k,
    input  sym_t [`LNK_LANES-1:0]  lnk_dat,

    // Link out, two cycles behind the input
    output logic [`LNK_LANES-1:0]  out_k,
    output sym_t [`LNK_LANES-1:0]  out_dat,
    output logic                   scrm_lock,
    output sym_t                   vbid,
    output logic                   vbid_vld,
    output logic                   sync
);

    logic                       lnk_en;
    lane_cnt_t                  lane_cnt;
    logic                       scrm_en;
    logic [`LNK_LANES-1:0]      par_k;
    sym_t [`LNK_LANES-1:0]      par_dat;
    sym_kind_t [`LNK_LANES-1:0] par_kind;
    logic [`LNK_LANES-1:0]      dsc_k;
    sym_t [`LNK_LANES-1:0]      dsc_dat;
    sym_kind_t [`LNK_LANES-1:0] dsc_kind;
    logic [`LNK_LANES-1:0]      lane_lock;

    // Control and status
    lnk_apb_regs i_regs
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .scrm_lock  (scrm_lock),
        .vbid       (vbid),
        .lnk_en     (lnk_en),
        .lane_cnt   (lane_cnt),
        .scrm_en    (scrm_en)
    );

    // Stage 1
    lnk_lane_parser i_parser
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .arst_n     (arst_n),
        .lnk_k      (lnk_k),
        .lnk_dat    (lnk_dat),
        .par_k      (par_k),
        .par_dat    (par_dat),
        .par_kind   (par_kind)
    );

    // Stage 2
    lnk_descrambler i_dscr
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .arst_n     (arst_n),
        .lnk_en     (lnk_en),
        .scrm_en    (scrm_en),
        .par_k      (par_k),
        .par_dat    (par_dat),
        .par_kind   (par_kind),
        .dsc_k      (dsc_k),
        .dsc_dat    (dsc_dat),
        .dsc_kind   (dsc_kind),
        .lane_lock  (lane_lock)
    );

    // Stage 3
    lnk_lock_vbid i_lock
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .arst_n     (arst_n),
        .lane_cnt   (lane_cnt),
        .lane_lock  (lane_lock),
        .dsc_k      (dsc_k),
        .dsc_dat    (dsc_dat),
        .dsc_kind   (dsc_kind),
        .scrm_lock  (scrm_lock),
        .vbid       (vbid),
        .vbid_vld   (vbid_vld),
        .sync       (sync)
    );

    // Symbol stream out, no handshake
    assign out_k   = dsc_k;
    assign out_dat = dsc_dat;

endmodule

/* logic/lnk_lock_vbid.sv */
`timescale 1ns/1ps
`include "lnk_params.svh"

module lnk_lock_vbid
import lnk_sym_pkg::*;
(
    input  logic                       LNK_CLK_IN,
    input  logic                       arst_n,

    // Active lane code, 1/2/3 for 1/2/4 lanes
    input  logic [1:0]                 lane_cnt,

    // From the descrambler
    input  logic [`LNK_LANES-1:0]      lane_lock,
    input  logic [`LNK_LANES-1:0]      dsc_k,
    input  sym_t [`LNK_LANES-1:0]      dsc_dat,
    input  sym_kind_t [`LNK_LANES-1:0] dsc_kind,

    output logic                       scrm_lock,
    output sym_t                       vbid,
    output logic                       vbid_vld,
    output logic                       sync
);

    logic all_lock; // Lock of the active lanes
    logic prev_bs;  // Lane 0 showed BS last cycle
    logic bs0;
    logic vbid_hit;

    // Only lanes in use take part
    always_comb
    begin
        case (lane_cnt)
            2'd1:    all_lock = lane_lock[0];
            2'd2:    all_lock = &lane_lock[1:0];
            2'd3:    all_lock = &lane_lock[3:0];
            default: all_lock = 1'b0;
        endcase
    end

    assign bs0      = (dsc_kind[0] == SYM_BS);
    assign vbid_hit = prev_bs & ~dsc_k[0]; // VB-ID is the data byte after BS

    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scrm_lock <= 1'b0;
            prev_bs   <= 1'b0;
            vbid      <= '0;
            vbid_vld  <= 1'b0;
            sync      <= 1'b0;
        end
        else
        begin
            scrm_lock <= all_lock;
            prev_bs   <= bs0;
            vbid_vld  <= vbid_hit; // Single cycle
            sync      <= bs0;      // One per BS
            if (vbid_hit)
                vbid <= dsc_dat[0]; // Held until the next BS
        end
    end

endmodule

/* logic/lnk_descrambler.sv */
`timescale 1ns/1ps
`include "lnk_params.svh"

module lnk_descrambler
import lnk_sym_pkg::*;
(
    input  logic                       LNK_CLK_IN,
    input  logic                       arst_n,

    // Control
    input  logic                       lnk_en,
    input  logic                       scrm_en,

    // From the parser
    input  logic [`LNK_LANES-1:0]      par_k,
    input  sym_t [`LNK_LANES-1:0]      par_dat,
    input  sym_kind_t [`LNK_LANES-1:0] par_kind,

    // To the lock stage
    output logic [`LNK_LANES-1:0]      dsc_k,
    output sym_t [`LNK_LANES-1:0]      dsc_dat,
    output sym_kind_t [`LNK_LANES-1:0] dsc_kind,
    output logic [`LNK_LANES-1:0]      lane_lock
);

    // Eight serial steps of x^16+x^5+x^4+x^3+1, key in the upper byte
    function automatic logic [23:0] lfsr_step8(input logic [15:0] s);
        logic [15:0] l;
        logic [7:0]  o;
        l = s;
        for (int b = 0; b < 8; b++)
        begin
            o[b] = l[15]; // Key bit b pairs with data bit b
            l    = {l[14:0], 1'b0} ^ (l[15] ? 16'h0039 : 16'h0000);
        end
        return {o, l};
    endfunction

    for (genvar g = 0; g < `LNK_LANES; g++)
    begin : gen_lane
        logic [15:0] lfsr;     // Lane state
        logic [15:0] lfsr_nxt; // After eight steps
        logic [7:0]  key;      // Taken before the advance
        logic        is_sr;
        logic        k_q;
        sym_kind_t   kind_q;
        logic        lock_q;
        sym_t        dat_q;

        assign {key, lfsr_nxt} = lfsr_step8(lfsr);
        assign is_sr = (par_kind[g] == SYM_SR);

        always_ff @(posedge LNK_CLK_IN or negedge arst_n)
        begin
            if (!arst_n)
            begin
                lfsr   <= LFSR_SEED;
                k_q    <= 1'b0;
                kind_q <= SYM_DATA;
                lock_q <= 1'b0;
            end
            else
            begin
                lfsr   <= is_sr ? LFSR_SEED : lfsr_nxt; // Runs even with scrm_en low
                k_q    <= par_k[g];
                kind_q <= par_kind[g];
                if (!lnk_en)
                    lock_q <= 1'b0;
                else if (is_sr)
                    lock_q <= 1'b1; // First SR aligns the lane
            end
        end

        // K codes are never scrambled
        always_ff @(posedge LNK_CLK_IN)
            dat_q <= (scrm_en && !par_k[g]) ? (par_dat[g] ^ key) : par_dat[g];

        assign dsc_k[g]     = k_q;
        assign dsc_kind[g]  = kind_q;
        assign dsc_dat[g]   = dat_q;
        assign lane_lock[g] = lock_q;
    end

endmodule

/* logic/lnk_lane_parser.sv */
`timescale 1ns/1ps
`include "lnk_params.svh"

module lnk_lane_parser
import lnk_sym_pkg::*;
(
    input  logic                            LNK_CLK_IN,
    input  logic                            arst_n,

    // Decoded symbols from the PHY
    input  logic [`LNK_LANES-1:0]           lnk_k,
    input  sym_t [`LNK_LANES-1:0]           lnk_dat,

    // Registered and classified
    output logic [`LNK_LANES-1:0]           par_k,
    output sym_t [`LNK_LANES-1:0]           par_dat,
    output sym_kind_t [`LNK_LANES-1:0]      par_kind
);

    sym_kind_t [`LNK_LANES-1:0] kind_d; // Classification before the register

    // Symbol type from K flag and byte
    function automatic sym_kind_t classify(input logic k, input sym_t dat);
        sym_kind_t res;
        if (!k)
            res = SYM_DATA;
        else
        begin
            case (dat)
                K_BS:    res = SYM_BS;
                K_BE:    res = SYM_BE;
                K_SR:    res = SYM_SR;
                default: res = SYM_KOTH; // Fill, BF and friends
            endcase
        end
        return res;
    endfunction

    always_comb
    begin
        for (int i = 0; i < `LNK_LANES; i++)
            kind_d[i] = classify(lnk_k[i], lnk_dat[i]);
    end

    // Control part of the stage
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            par_k    <= '0;
            par_kind <= {`LNK_LANES{SYM_DATA}};
        end
        else
        begin
            par_k    <= lnk_k;
            par_kind <= kind_d;
        end
    end

    // Payload, no reset
    always_ff @(posedge LNK_CLK_IN)
        par_dat <= lnk_dat;

endmodule

/* logic/lnk_apb_regs.sv */
`timescale 1ns/1ps
`include "lnk_params.svh"

module lnk_apb_regs
import lnk_sym_pkg::*;
import lnk_ctl_pkg::*;
(
    input  logic                   LNK_CLK_IN,
    input  logic                   arst_n,

    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`LNK_APB_AW-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,

    // Status from the lock stage
    input  logic                   scrm_lock,
    input  sym_t                   vbid,

    // Control to the pipeline
    output logic                   lnk_en,
    output lane_cnt_t              lane_cnt,
    output logic                   scrm_en
);

    ctl_word_u ctl_q; // Stored control word
    ctl_word_u wr_w;  // Incoming write data, field view
    logic      acc;   // Access phase
    logic      sel_ctl;
    logic      sel_sta;

    assign acc     = psel & penable;
    assign sel_ctl = (paddr == `LNK_REG_CTL);
    assign sel_sta = (paddr == `LNK_REG_STA);

    // Zero wait states
    assign pready  = acc;
    assign pslverr = acc & ~(sel_ctl | sel_sta); // Unmapped offset

    assign wr_w = ctl_word_u'(pwdata);

    // Control write, reserved bits stay zero
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
            ctl_q.raw <= '0;
        else if (acc && pwrite && sel_ctl)
        begin
            ctl_q.f.lnk_en   <= wr_w.f.lnk_en;
            ctl_q.f.lane_cnt <= wr_w.f.lane_cnt;
            ctl_q.f.scrm_en  <= wr_w.f.scrm_en;
        end
    end

    // Read mux; status write is silently dropped
    always_comb
    begin
        prdata = '0;
        if (psel && !pwrite)
        begin
            if (sel_ctl)
                prdata = ctl_q.raw;
            else if (sel_sta)
            begin
                prdata[0]    = scrm_lock; // Combined lock
                prdata[15:8] = vbid;      // Last VB-ID
            end
        end
    end

    assign lnk_en   = ctl_q.f.lnk_en;
    assign lane_cnt = ctl_q.f.lane_cnt;
    assign scrm_en  = ctl_q.f.scrm_en;

endmodule

/* logic/lnk_ctl_pkg.sv */
package lnk_ctl_pkg;

    // Active lane code, same coding as the link layer control
    typedef enum logic [1:0]
    {
        LANES_NONE = 2'd0, // Link idle
        LANES_1    = 2'd1, // Lane 0 only
        LANES_2    = 2'd2, // Lanes 0 and 1
        LANES_4    = 2'd3  // All four lanes
    } lane_cnt_t;

    // Control register layout, LSB first from the bottom
    typedef struct packed
    {
        logic [27:0] rsvd;     // Reads zero
        logic        scrm_en;  // Bit 3
        lane_cnt_t   lane_cnt; // Bits 2:1
        logic        lnk_en;   // Bit 0
    } ctl_fields_t;

    // Same 32 bits seen as bus word or as fields
    typedef union packed
    {
        logic [31:0] raw;
        ctl_fields_t f;
    } ctl_word_u;

endpackage

/* logic/lnk_sym_pkg.sv */
`include "lnk_params.svh"

package lnk_sym_pkg;

    // One lane's data byte
    typedef logic [`LNK_SYM_W-1:0] sym_t;

    // Parser result per lane
    typedef enum logic [2:0]
    {
        SYM_DATA = 3'd0, // Plain data byte
        SYM_BS   = 3'd1, // Blanking start
        SYM_BE   = 3'd2, // Blanking end
        SYM_SR   = 3'd3, // Scrambler reset
        SYM_KOTH = 3'd4  // Any other K code
    } sym_kind_t;

    // K28.5
    localparam sym_t K_BS = 8'hBC;

    // K27.7
    localparam sym_t K_BE = 8'hFB;

    // K28.0
    localparam sym_t K_SR = 8'h1C;

    // Descrambler reload value on SR
    localparam logic [15:0] LFSR_SEED = 16'hFFFF;

endpackage

/* logic/lnk_params.svh */
`ifndef LNK_PARAMS_SVH
`define LNK_PARAMS_SVH

// Physical lanes
`define LNK_LANES 4

// Data bits per symbol
`define LNK_SYM_W 8

// APB address width in bits
`define LNK_APB_AW 4

// Register map, byte offsets
`define LNK_REG_CTL 4'h0 // Control
`define LNK_REG_STA 4'h4 // Status

`endif
